//--- verilog.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_decoder.sv
hw/cpu_regfile.sv
hw/cpu_alu.sv
hw/cpu_branch_unit.sv
hw/cpu_exec_core.sv
verification/tb_cpu_exec_core.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_cpu_exec_core \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

//--- verification/tb_cpu_exec_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_exec_core;

    // Major opcodes, bits 6 to 2 of the instruction
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;

    // Instruction classes for the random generator
    localparam int K_OP     = 0;
    localparam int K_OPIMM  = 1;
    localparam int K_LUI    = 2;
    localparam int K_AUIPC  = 3;
    localparam int K_LOAD   = 4;
    localparam int K_STORE  = 5;
    localparam int K_BRANCH = 6;
    localparam int K_JAL    = 7;
    localparam int K_JALR   = 8;

    localparam logic [31:0] LOAD_XOR = 32'h5a5a0000;

    logic        I_clk;
    logic        reset;
    logic        en;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] load_data;
    logic [31:0] result;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] next_pc;
    logic        branch_taken;
    logic [2:0]  bus_op;
    logic [31:0] bus_addr;
    logic [31:0] store_data;
    logic        bus_load;
    logic        bus_store;

    logic [31:0] lfsr;
    logic [31:0] mregs [32];
    logic        pend_valid;
    logic [31:0] pend_instr;
    logic [31:0] pend_pc;
    logic        cleared;
    int          n_checks;
    int          n_errors;

    // Expected outputs of the instruction in its result cycle
    logic        exp_write;
    logic        exp_wb;
    logic [4:0]  exp_rd;
    logic [31:0] exp_result;
    logic        exp_taken;
    logic [31:0] exp_next_pc;
    logic        exp_load;
    logic        exp_store;
    logic [2:0]  exp_bus_op;
    logic [31:0] exp_addr;
    logic [31:0] exp_sdata;

    cpu_exec_core dut_i (
        .I_clk        (I_clk),
        .reset        (reset),
        .en           (en),
        .instr        (instr),
        .pc           (pc),
        .load_data    (load_data),
        .result       (result),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .next_pc      (next_pc),
        .branch_taken (branch_taken),
        .bus_op       (bus_op),
        .bus_addr     (bus_addr),
        .store_data   (store_data),
        .bus_load     (bus_load),
        .bus_store    (bus_store)
    );

    always #20 I_clk = ~I_clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] encode_fields(input logic [6:0] f7, input logic [4:0] f_rs2,
                                                  input logic [4:0] f_rs1, input logic [2:0] f3,
                                                  input logic [4:0] f_rd, input logic [4:0] opc);
        return {f7, f_rs2, f_rs1, f3, f_rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt_sub,
                                            input logic alt_sra, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            3'b000:  return alt_sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt_sra ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Products of extended operands, wrapped to 64 bits
    function automatic logic [31:0] mul_ref(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (f3)
            3'b001:  p = sa * sb;
            3'b010:  p = sa * ub;
            default: p = ua * ub;
        endcase
        return (f3 == 3'b000) ? p[31:0] : p[63:32];
    endfunction

    task automatic model_execute(input logic [31:0] w, input logic [31:0] p);
        logic [4:0]  opc;
        logic [2:0]  f3;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        cond;
        opc   = w[6:2];
        f3    = w[14:12];
        rs1v  = mregs[w[19:15]];
        rs2v  = mregs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        cond  = 1'b0;
        exp_write   = 1'b0;
        exp_rd      = w[11:7];
        exp_result  = '0;
        exp_taken   = 1'b0;
        exp_next_pc = p + 32'd4;
        exp_load    = 1'b0;
        exp_store   = 1'b0;
        exp_bus_op  = 3'd0;
        exp_addr    = '0;
        exp_sdata   = '0;
        case (opc)
            OPC_OPIMM: begin
                exp_write  = 1'b1;
                exp_result = alu_ref(f3, 1'b0, w[30], rs1v, imm_i);
            end
            OPC_OP: begin
                exp_write  = 1'b1;
                exp_result = w[25] ? mul_ref(f3, rs1v, rs2v)
                                   : alu_ref(f3, w[30], w[30], rs1v, rs2v);
            end
            OPC_LUI: begin
                exp_write  = 1'b1;
                exp_result = imm_u;
            end
            OPC_AUIPC: begin
                exp_write  = 1'b1;
                exp_result = p + imm_u;
            end
            OPC_LOAD: begin
                exp_write  = 1'b1;
                exp_load   = 1'b1;
                exp_addr   = rs1v + imm_i;
                exp_result = exp_addr ^ LOAD_XOR;
                // Byte, half, word, then the unsigned forms
                case (f3)
                    3'b000:  exp_bus_op = 3'd0;
                    3'b001:  exp_bus_op = 3'd1;
                    3'b010:  exp_bus_op = 3'd2;
                    3'b100:  exp_bus_op = 3'd3;
                    default: exp_bus_op = 3'd4;
                endcase
            end
            OPC_STORE: begin
                exp_store  = 1'b1;
                exp_addr   = rs1v + imm_s;
                exp_sdata  = rs2v;
                exp_bus_op = (f3 == 3'b000) ? 3'd5 : (f3 == 3'b001) ? 3'd6 : 3'd7;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  cond = (rs1v == rs2v);
                    3'b001:  cond = (rs1v != rs2v);
                    3'b100:  cond = ($signed(rs1v) < $signed(rs2v));
                    3'b101:  cond = ($signed(rs1v) >= $signed(rs2v));
                    3'b110:  cond = (rs1v < rs2v);
                    default: cond = (rs1v >= rs2v);
                endcase
                exp_taken = cond;
                if (cond) begin
                    exp_next_pc = p + imm_b;
                end
            end
            OPC_JAL: begin
                exp_write   = 1'b1;
                exp_taken   = 1'b1;
                exp_result  = p + 32'd4;
                exp_next_pc = (p + imm_j) & ~32'd1;
            end
            OPC_JALR: begin
                exp_write   = 1'b1;
                exp_taken   = 1'b1;
                exp_result  = p + 32'd4;
                exp_next_pc = (rs1v + imm_i) & ~32'd1;
            end
            default: begin
            end
        endcase
        exp_wb = exp_write && (exp_rd != 5'd0);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        check_val("wb_en", 32'(wb_en), 32'(exp_wb));
        if (exp_write) begin
            check_val("result", result, exp_result);
        end
        if (exp_wb) begin
            check_val("wb_rd", 32'(wb_rd), 32'(exp_rd));
        end
        check_val("branch_taken", 32'(branch_taken), 32'(exp_taken));
        check_val("next_pc", next_pc, exp_next_pc);
        check_val("bus_load", 32'(bus_load), 32'(exp_load));
        check_val("bus_store", 32'(bus_store), 32'(exp_store));
        if (exp_load || exp_store) begin
            check_val("bus_op", 32'(bus_op), 32'(exp_bus_op));
            check_val("bus_addr", bus_addr, exp_addr);
        end
        if (exp_store) begin
            check_val("store_data", store_data, exp_sdata);
        end
        if (exp_wb) begin
            mregs[exp_rd] = exp_result;
        end
    endtask

    task automatic check_idle();
        check_val("wb_en", 32'(wb_en), 32'd0);
        check_val("bus_load", 32'(bus_load), 32'd0);
        check_val("bus_store", 32'(bus_store), 32'd0);
        check_val("branch_taken", 32'(branch_taken), 32'd0);
    endtask

    // One clock: drive the next issue, then check the instruction now in its result cycle
    task automatic step(input logic do_issue, input logic [31:0] w, input logic [31:0] p);
        logic        cur_valid;
        logic [31:0] cur_instr;
        logic [31:0] cur_pc;
        @(posedge I_clk);
        #2;
        cur_valid  = pend_valid;
        cur_instr  = pend_instr;
        cur_pc     = pend_pc;
        en         = do_issue;
        instr      = w;
        pc         = p;
        pend_valid = do_issue;
        pend_instr = w;
        pend_pc    = p;
        if (cur_valid) begin
            model_execute(cur_instr, cur_pc);
            load_data = exp_addr ^ LOAD_XOR;
        end
        @(negedge I_clk);
        if (cur_valid) begin
            check_outputs();
        end else begin
            check_idle();
        end
    endtask

    task automatic make_instr(input int kind, output logic [31:0] w);
        logic [31:0] r;
        logic [6:0]  f7;
        logic [4:0]  lo;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3r;
        logic [2:0]  f3;
        rand_bits(7, r);
        f7 = r[6:0];
        rand_bits(5, r);
        lo = r[4:0];
        // Eight registers only, so dependencies are frequent
        rand_bits(3, r);
        rs1 = {2'b00, r[2:0]};
        rand_bits(3, r);
        rs2 = {2'b00, r[2:0]};
        rand_bits(3, r);
        rd = {2'b00, r[2:0]};
        rand_bits(3, r);
        f3r = r[2:0];
        case (kind)
            K_OP: begin
                if (f7[6]) begin
                    w = encode_fields(7'b0000001, rs2, rs1, {1'b0, f3r[1:0]}, rd, OPC_OP);
                end else if (f3r == 3'b000 || f3r == 3'b101) begin
                    w = encode_fields({1'b0, f7[0], 5'b0}, rs2, rs1, f3r, rd, OPC_OP);
                end else begin
                    w = encode_fields(7'b0, rs2, rs1, f3r, rd, OPC_OP);
                end
            end
            K_OPIMM: w = encode_fields(f7, lo, rs1, f3r, rd, OPC_OPIMM);
            K_LUI:   w = encode_fields(f7, lo, rs1, f3r, rd, OPC_LUI);
            K_AUIPC: w = encode_fields(f7, lo, rs1, f3r, rd, OPC_AUIPC);
            K_LOAD: begin
                f3 = (f3r == 3'b011) ? 3'b010 : (f3r[2:1] == 2'b11) ? {2'b10, f3r[0]} : f3r;
                w  = encode_fields(f7, lo, rs1, f3, rd, OPC_LOAD);
            end
            K_STORE: begin
                f3 = (f3r[1:0] == 2'b11) ? 3'b010 : {1'b0, f3r[1:0]};
                w  = encode_fields(f7, rs2, rs1, f3, lo, OPC_STORE);
            end
            K_BRANCH: begin
                f3 = (f3r[2:1] == 2'b01) ? {1'b1, f3r[1:0]} : f3r;
                w  = encode_fields(f7, rs2, rs1, f3, lo, OPC_BRANCH);
            end
            K_JAL:   w = encode_fields(f7, lo, rs1, f3r, rd, OPC_JAL);
            default: w = encode_fields(f7, lo, rs1, 3'b000, rd, OPC_JALR);
        endcase
    endtask

    task automatic issue_word(input logic [31:0] w);
        logic [31:0] r;
        rand_bits(30, r);
        step(1'b1, w, {r[29:0], 2'b00});
    endtask

    task automatic issue_kind(input int kind);
        logic [31:0] w;
        make_instr(kind, w);
        issue_word(w);
    endtask

    // Weighted toward ALU work and memory access
    task automatic pick_kind(output int kind);
        logic [31:0] r;
        rand_bits(4, r);
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: kind = K_OP;
            4'd4, 4'd5:             kind = K_OPIMM;
            4'd6:                   kind = K_LUI;
            4'd7:                   kind = K_AUIPC;
            4'd8, 4'd9:             kind = K_LOAD;
            4'd10, 4'd11:           kind = K_STORE;
            4'd12, 4'd13:           kind = K_BRANCH;
            4'd14:                  kind = K_JAL;
            default:                kind = K_JALR;
        endcase
    endtask

    task automatic run_tests();
        logic [31:0] r;
        int          kind;
        // Reads of zeroed registers, then x0 as destination
        rand_bits(12, r);
        issue_word(encode_fields(r[11:5], r[4:0], 5'd7, 3'b000, 5'd6, OPC_OPIMM));
        rand_bits(12, r);
        issue_word(encode_fields(r[11:5], r[4:0], 5'd0, 3'b000, 5'd1, OPC_OPIMM));
        rand_bits(12, r);
        issue_word(encode_fields(r[11:5], r[4:0], 5'd0, 3'b100, 5'd2, OPC_OPIMM));
        rand_bits(5, r);
        issue_word(encode_fields(7'b0000000, r[4:0], 5'd1, 3'b001, 5'd3, OPC_OPIMM));
        rand_bits(5, r);
        issue_word(encode_fields(7'b0100000, r[4:0], 5'd2, 3'b101, 5'd4, OPC_OPIMM));
        rand_bits(5, r);
        issue_word(encode_fields(7'b0000000, r[4:0], 5'd2, 3'b101, 5'd5, OPC_OPIMM));
        rand_bits(12, r);
        issue_word(encode_fields(r[11:5], r[4:0], 5'd1, 3'b000, 5'd0, OPC_OPIMM));
        for (int i = 0; i < 20; i++) begin
            issue_kind(K_OPIMM);
        end
        // Back to back register ops through the forwarding path
        for (int i = 0; i < 40; i++) begin
            issue_kind(K_OP);
        end
        for (int i = 0; i < 10; i++) begin
            issue_kind((i % 2 == 0) ? K_LUI : K_AUIPC);
        end
        for (int i = 0; i < 30; i++) begin
            rand_bits(3, r);
            issue_kind((r[2:0] == 3'd6) ? K_JAL : (r[2:0] == 3'd7) ? K_JALR : K_BRANCH);
        end
        for (int i = 0; i < 20; i++) begin
            rand_bits(1, r);
            issue_kind(r[0] ? K_STORE : K_LOAD);
        end
        // Mixed traffic with idle gaps
        for (int i = 0; i < 60; i++) begin
            pick_kind(kind);
            issue_kind(kind);
            rand_bits(2, r);
            for (int g = 0; g < int'(r[1:0]); g++) begin
                step(1'b0, 32'h0, 32'h0);
            end
        end
        step(1'b0, 32'h0, 32'h0);
        step(1'b0, 32'h0, 32'h0);
    endtask

    initial begin
        I_clk      = 1'b0;
        reset      = 1'b1;
        en         = 1'b0;
        instr      = '0;
        pc         = '0;
        load_data  = '0;
        lfsr       = 32'h4683f46d;
        pend_valid = 1'b0;
        pend_instr = '0;
        pend_pc    = '0;
        cleared    = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (8) @(posedge I_clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < 16 && !cleared; i++) begin
            @(negedge I_clk);
            if (!wb_en && !bus_load && !bus_store && !branch_taken) begin
                cleared = 1'b1;
            end
        end
        if (!cleared) begin
            $display("Timed out waiting for the strobe outputs to go low after reset");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            run_tests();
            $display("Checks: %0d, errors: %0d", n_checks, n_errors);
            if (n_errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_exec_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_exec_core
    import cpu_pkg::*;
(
    input  logic                       I_clk,
    input  logic                       reset,
    input  logic                       en,
    input  logic [`CPU_XLEN-1:0]       instr,
    input  logic [`CPU_XLEN-1:0]       pc,
    input  logic [`CPU_XLEN-1:0]       load_data,
    output logic [`CPU_XLEN-1:0]       result,
    output logic                       wb_en,
    output logic [`CPU_REG_ADDR_W-1:0] wb_rd,
    output logic [`CPU_XLEN-1:0]       next_pc,
    output logic                       branch_taken,
    output bus_op_e                    bus_op,
    output logic [`CPU_XLEN-1:0]       bus_addr,
    output logic [`CPU_XLEN-1:0]       store_data,
    output logic                       bus_load,
    output logic                       bus_store
);

    logic [`CPU_REG_ADDR_W-1:0] rs1_addr;
    logic [`CPU_REG_ADDR_W-1:0] rs2_addr;
    logic [`CPU_XLEN-1:0]       imm;
    opcode_e                    opcode;
    logic                       writeback;
    logic [5:0]                 branch_mask;
    alu_op_e                    alu_op;
    alu_src1_e                  alu_src1;
    alu_src2_e                  alu_src2;
    reg_src_e                   reg_src;
    logic [`CPU_XLEN-1:0]       rs1_val;
    logic [`CPU_XLEN-1:0]       rs2_val;
    logic [`CPU_XLEN-1:0]       alu_a;
    logic [`CPU_XLEN-1:0]       alu_b;
    logic [`CPU_XLEN-1:0]       alu_y;
    logic [`CPU_XLEN-1:0]       link;
    logic                       bru_taken;
    logic [`CPU_XLEN-1:0]       pc_q;
    logic                       issue_valid;

    always_ff @(posedge I_clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= en;
        end
    end

    always_ff @(posedge I_clk) begin
        if (en) begin
            pc_q <= pc;
        end
    end

    // funct3 left open, bus_op already carries the access width
    cpu_decoder decoder_i (
        .I_clk       (I_clk),
        .en          (en),
        .instr       (instr),
        .rs1         (rs1_addr),
        .rs2         (rs2_addr),
        .rd          (wb_rd),
        .imm         (imm),
        .opcode      (opcode),
        .funct3      (),
        .writeback   (writeback),
        .branch_mask (branch_mask),
        .alu_op      (alu_op),
        .bus_op      (bus_op),
        .alu_src1    (alu_src1),
        .alu_src2    (alu_src2),
        .reg_src     (reg_src)
    );

    cpu_regfile regfile_i (
        .I_clk    (I_clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_en    (wb_en),
        .rd_addr  (wb_rd),
        .rd_data  (result),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    assign alu_a = (alu_src1 == SRC1_PC)  ? pc_q : rs1_val;
    assign alu_b = (alu_src2 == SRC2_IMM) ? imm  : rs2_val;

    cpu_alu alu_i (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    cpu_branch_unit bru_i (
        .opcode      (opcode),
        .branch_mask (branch_mask),
        .rs1_val     (alu_a),
        .rs2_val     (alu_b),
        .pc          (pc_q),
        .imm         (imm),
        .alu_y       (alu_y),
        .taken       (bru_taken),
        .next_pc     (next_pc),
        .link        (link)
    );

    // Writeback select, status registers not present so MSR reads zero
    always_comb begin
        case (reg_src)
            REG_SRC_BUS: result = load_data;
            REG_SRC_BRU: result = link;
            REG_SRC_MSR: result = '0;
            default:     result = alu_y;
        endcase
    end

    assign wb_en = issue_valid && writeback && (wb_rd != '0);

    assign bus_addr     = alu_y;
    assign store_data   = rs2_val;
    assign bus_load     = issue_valid && (opcode == OP_LOAD);
    assign bus_store    = issue_valid && (opcode == OP_STORE);
    assign branch_taken = issue_valid && bru_taken;

endmodule

`default_nettype wire

//--- hw/cpu_branch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_branch_unit
    import cpu_pkg::*;
(
    input  opcode_e              opcode,
    input  logic [5:0]           branch_mask,
    input  logic [`CPU_XLEN-1:0] rs1_val,
    input  logic [`CPU_XLEN-1:0] rs2_val,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_XLEN-1:0] imm,
    input  logic [`CPU_XLEN-1:0] alu_y,
    output logic                 taken,
    output logic [`CPU_XLEN-1:0] next_pc,
    output logic [`CPU_XLEN-1:0] link
);

    logic       eq;
    logic       lt;
    logic       ltu;
    logic       cond_hit;
    logic       is_jump;
    logic [5:0] cond_vec;

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    // Ordered BGEU, BLTU, BGE, BLT, BNE, BEQ to line up with the mask
    assign cond_vec = {~ltu, ltu, ~lt, lt, ~eq, eq};
    assign cond_hit = |(branch_mask & cond_vec);

    assign is_jump = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign taken   = cond_hit || is_jump;

    assign link = pc + `CPU_XLEN'd4;

    always_comb begin
        if (is_jump) begin
            // Jump target from the ALU sum, bit 0 dropped
            next_pc = {alu_y[`CPU_XLEN-1:1], 1'b0};
        end else if (cond_hit) begin
            next_pc = pc + imm;
        end else begin
            next_pc = link;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  alu_op_e              op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] y
);

    logic                          a_signed;
    logic                          b_signed;
    logic signed [`CPU_XLEN:0]     a_ext;
    logic signed [`CPU_XLEN:0]     b_ext;
    logic signed [2*`CPU_XLEN+1:0] prod;
    logic [4:0]                    shamt;

    // One extra bit per operand covers all three signedness mixes
    assign a_signed = (op == ALU_MULH) || (op == ALU_MULHSU);
    assign b_signed = (op == ALU_MULH);
    assign a_ext    = {a_signed & a[`CPU_XLEN-1], a};
    assign b_ext    = {b_signed & b[`CPU_XLEN-1], b};
    assign prod     = a_ext * b_ext;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_SLL:    y = a << shamt;
            ALU_SLT:    y = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {{(`CPU_XLEN-1){1'b0}}, a < b};
            ALU_XOR:    y = a ^ b;
            ALU_SRL:    y = a >> shamt;
            ALU_SRA:    y = $unsigned($signed(a) >>> shamt);
            ALU_OR:     y = a | b;
            ALU_AND:    y = a & b;
            ALU_MUL:    y = prod[`CPU_XLEN-1:0];
            // High half for every signed and unsigned mix
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU:  y = prod[2*`CPU_XLEN-1:`CPU_XLEN];
            default:    y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cpu_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_regfile (
    input  logic                       I_clk,
    input  logic                       reset,
    input  logic [`CPU_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`CPU_REG_ADDR_W-1:0] rs2_addr,
    input  logic                       rd_en,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr,
    input  logic [`CPU_XLEN-1:0]       rd_data,
    output logic [`CPU_XLEN-1:0]       rs1_val,
    output logic [`CPU_XLEN-1:0]       rs2_val
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];
    logic                 wr_ok;

    // x0 is never written
    assign wr_ok = rd_en && (rd_addr != '0);

    // Read with bypass of a write landing at the same edge
    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_ok && rd_addr == addr) begin
            return rd_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge I_clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            rs1_val <= '0;
            rs2_val <= '0;
        end else begin
            if (wr_ok) begin
                regs[rd_addr] <= rd_data;
            end
            rs1_val <= read_port(rs1_addr);
            rs2_val <= read_port(rs2_addr);
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_params.svh"

module cpu_decoder
    import cpu_pkg::*;
(
    input  logic                       I_clk,
    input  logic                       en,
    input  logic [`CPU_XLEN-1:0]       instr,
    output logic [`CPU_REG_ADDR_W-1:0] rs1,
    output logic [`CPU_REG_ADDR_W-1:0] rs2,
    output logic [`CPU_REG_ADDR_W-1:0] rd,
    output logic [`CPU_XLEN-1:0]       imm,
    output opcode_e                    opcode,
    output logic [2:0]                 funct3,
    output logic                       writeback,
    output logic [5:0]                 branch_mask,
    output alu_op_e                    alu_op,
    output bus_op_e                    bus_op,
    output alu_src1_e                  alu_src1,
    output alu_src2_e                  alu_src2,
    output reg_src_e                   reg_src
);

    logic [`CPU_XLEN-1:0] instr_q;
    logic [6:0]           funct7;
    alu_op_e              op_alu_op;
    alu_op_e              opimm_alu_op;
    bus_op_e              load_bus_op;
    bus_op_e              store_bus_op;

    always_ff @(posedge I_clk) begin
        if (en) begin
            instr_q <= instr;
        end
    end

    // Source fields taken from the incoming word so the register read overlaps decode
    // LUI runs as x0 plus immediate
    assign rs1 = (instr[6:2] == OP_LUI) ? '0 : instr[19:15];
    assign rs2 = instr[24:20];

    assign opcode = opcode_e'(instr_q[6:2]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign rd     = instr_q[11:7];

    // Immediate formats
    always_comb begin
        case (opcode)
            OP_STORE:
                imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            OP_BRANCH:
                imm = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {instr_q[31:12], 12'b0};
            OP_JAL:
                imm = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};
            default:
                imm = {{20{instr_q[31]}}, instr_q[31:20]};
        endcase
    end

    always_comb begin
        case (opcode)
            OP_OP, OP_OPIMM, OP_LUI, OP_AUIPC, OP_LOAD, OP_JAL, OP_JALR: writeback = 1'b1;
            default:                                                     writeback = 1'b0;
        endcase

        alu_src1 = (opcode == OP_JAL || opcode == OP_AUIPC) ? SRC1_PC : SRC1_REG;
        alu_src2 = (opcode == OP_OP || opcode == OP_BRANCH) ? SRC2_REG : SRC2_IMM;

        case (opcode)
            OP_LOAD:         reg_src = REG_SRC_BUS;
            OP_JAL, OP_JALR: reg_src = REG_SRC_BRU;
            OP_SYSTEM:       reg_src = REG_SRC_MSR;
            default:         reg_src = REG_SRC_ALU;
        endcase

        // One mask bit per condition, only for conditional branches
        branch_mask = '0;
        if (opcode == OP_BRANCH) begin
            case (funct3)
                3'b000:  branch_mask[0] = 1'b1;
                3'b001:  branch_mask[1] = 1'b1;
                3'b100:  branch_mask[2] = 1'b1;
                3'b101:  branch_mask[3] = 1'b1;
                3'b110:  branch_mask[4] = 1'b1;
                3'b111:  branch_mask[5] = 1'b1;
                default: branch_mask = '0;
            endcase
        end
    end

    always_comb begin
        // funct7 bit 0 selects the multiply group
        case ({funct7[0], funct3})
            4'b0_000: op_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
            4'b0_001: op_alu_op = ALU_SLL;
            4'b0_010: op_alu_op = ALU_SLT;
            4'b0_011: op_alu_op = ALU_SLTU;
            4'b0_100: op_alu_op = ALU_XOR;
            4'b0_101: op_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            4'b0_110: op_alu_op = ALU_OR;
            4'b0_111: op_alu_op = ALU_AND;
            4'b1_000: op_alu_op = ALU_MUL;
            4'b1_001: op_alu_op = ALU_MULH;
            4'b1_010: op_alu_op = ALU_MULHSU;
            4'b1_011: op_alu_op = ALU_MULHU;
            default:  op_alu_op = ALU_ADD;
        endcase

        case (funct3)
            3'b001:  opimm_alu_op = ALU_SLL;
            3'b010:  opimm_alu_op = ALU_SLT;
            3'b011:  opimm_alu_op = ALU_SLTU;
            3'b100:  opimm_alu_op = ALU_XOR;
            3'b101:  opimm_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  opimm_alu_op = ALU_OR;
            3'b111:  opimm_alu_op = ALU_AND;
            default: opimm_alu_op = ALU_ADD;
        endcase

        case (opcode)
            OP_OP:    alu_op = op_alu_op;
            OP_OPIMM: alu_op = opimm_alu_op;
            default:  alu_op = ALU_ADD;
        endcase

        case (funct3)
            3'b000:  load_bus_op = BUS_READB;
            3'b001:  load_bus_op = BUS_READH;
            3'b010:  load_bus_op = BUS_READW;
            3'b100:  load_bus_op = BUS_READBU;
            default: load_bus_op = BUS_READHU;
        endcase

        case (funct3)
            3'b000:  store_bus_op = BUS_WRITEB;
            3'b001:  store_bus_op = BUS_WRITEH;
            default: store_bus_op = BUS_WRITEW;
        endcase

        bus_op = (opcode == OP_LOAD) ? load_bus_op : store_bus_op;
    end

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Major opcode, instruction bits 6 to 2
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_OPIMM  = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_OP     = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011,
        OP_SYSTEM = 5'b11100
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_MUL    = 4'd10,
        ALU_MULH   = 4'd11,
        ALU_MULHSU = 4'd12,
        ALU_MULHU  = 4'd13
    } alu_op_e;

    // Memory access type, loads first
    typedef enum logic [2:0] {
        BUS_READB  = 3'd0,
        BUS_READH  = 3'd1,
        BUS_READW  = 3'd2,
        BUS_READBU = 3'd3,
        BUS_READHU = 3'd4,
        BUS_WRITEB = 3'd5,
        BUS_WRITEH = 3'd6,
        BUS_WRITEW = 3'd7
    } bus_op_e;

    typedef enum logic {SRC1_REG = 1'b0, SRC1_PC  = 1'b1} alu_src1_e;
    typedef enum logic {SRC2_REG = 1'b0, SRC2_IMM = 1'b1} alu_src2_e;

    // Writeback source
    typedef enum logic [1:0] {
        REG_SRC_ALU = 2'd0,
        REG_SRC_BUS = 2'd1,
        REG_SRC_BRU = 2'd2,
        REG_SRC_MSR = 2'd3
    } reg_src_e;

endpackage

`default_nettype wire

//--- hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path and address width
`define CPU_XLEN 32

// Register file geometry
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_W 5

`endif
